/* Bender.yml */
package:
  name: ex_stage

sources:
  - files:
      - design/lsu_pkg.sv
      - design/ex_pkg.sv
      - design/ex_ctrl.sv
      - design/ex_alu.sv
      - design/ex_lsu_req.sv
      - design/ex_stage.sv
  - target: test
    files:
      - dv/ex_stage_chk.sv
      - dv/ex_stage_tb.sv

/* all.f */
design/lsu_pkg.sv
design/ex_pkg.sv
design/ex_ctrl.sv
design/ex_alu.sv
design/ex_lsu_req.sv
design/ex_stage.sv
dv/ex_stage_chk.sv
dv/ex_stage_tb.sv

/* design/ex_alu.sv */
module ex_alu (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  ex_pkg::alu_op_e   alu_op,
    input  logic [31:0]       src1,
    input  logic [31:0]       src2,
    output logic [31:0]       result,
    output logic              complete
);

    logic                         is_mul;
    logic                         mul_start;
    logic                         mul_done;
    logic [ex_pkg::MUL_CNT_W-1:0] steps_left; // 0 means idle or finished
    logic [31:0]                  mcand;      // shifted left each step
    logic [31:0]                  mplier;     // shifted right each step
    logic [31:0]                  acc;        // low word of the partial product
    logic [31:0]                  simple_res;
    logic [32:0]                  diff;       // sub with borrow for sltu
    logic [4:0]                   shamt;

    assign is_mul    = (alu_op == ex_pkg::ALU_MUL);
    assign mul_start = start & is_mul;
    assign shamt     = src2[4:0];
    assign diff      = {1'b0, src1} - {1'b0, src2};

    always_comb begin
        case (alu_op)
            ex_pkg::ALU_ADD:  simple_res = src1 + src2;
            ex_pkg::ALU_SUB:  simple_res = diff[31:0];
            ex_pkg::ALU_SLT:  simple_res = {31'd0, $signed(src1) < $signed(src2)};
            ex_pkg::ALU_SLTU: simple_res = {31'd0, diff[32]};  // borrow out
            ex_pkg::ALU_AND:  simple_res = src1 & src2;
            ex_pkg::ALU_OR:   simple_res = src1 | src2;
            ex_pkg::ALU_NOR:  simple_res = ~(src1 | src2);
            ex_pkg::ALU_XOR:  simple_res = src1 ^ src2;
            ex_pkg::ALU_SLL:  simple_res = src1 << shamt;
            ex_pkg::ALU_SRL:  simple_res = src1 >> shamt;
            ex_pkg::ALU_SRA:  simple_res = $unsigned($signed(src1) >>> shamt);
            ex_pkg::ALU_LUI:  simple_res = src2;               // immediate already shifted by decode
            default:          simple_res = 32'd0;
        endcase
    end

    // step counter, the start edge already performs step one
    always_ff @(posedge clk) begin
        if (!resetn) begin
            steps_left <= '0;
        end else if (mul_start) begin
            steps_left <= ex_pkg::MUL_LAST;
        end else if (steps_left != '0) begin
            steps_left <= steps_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            acc    <= src2[0] ? src1 : 32'd0;
            mcand  <= src1 << 1;
            mplier <= src2 >> 1;
        end else if (steps_left != '0) begin
            acc    <= acc + (mplier[0] ? mcand : 32'd0);
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // stale state is still visible during the start cycle
    assign mul_done = ~start & (steps_left == '0);

    assign complete = ~is_mul | mul_done;
    assign result   = is_mul ? acc : simple_res;

endmodule

/* design/ex_ctrl.sv */
module ex_ctrl (
    input  logic             clk,
    input  logic             resetn,
    input  logic             id_to_ex_valid,
    input  ex_pkg::ex_in_t   id_to_ex_bus,
    input  logic             mem_allowin,
    input  logic             flush,
    input  logic [63:0]      counter,
    input  logic [31:0]      alu_result,
    input  logic             alu_complete,
    input  logic             ale,
    output logic             ex_allowin,
    output logic             ex_to_mem_valid,
    output ex_pkg::ex_in_t   inst,
    output logic             stage_valid,
    output logic             alu_start,
    output ex_pkg::ex_fwd_t  ex_to_id_bus,
    output ex_pkg::ex_out_t  ex_to_mem_bus
);

    logic        load;         // accept edge
    logic        ready_go;
    logic [31:0] counter_half;
    logic [31:0] result_sel;

    assign ready_go        = alu_complete;
    assign ex_allowin      = ~stage_valid | (ready_go & mem_allowin);
    assign ex_to_mem_valid = stage_valid & ready_go;
    assign load            = id_to_ex_valid & ex_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stage_valid <= 1'b0;
        end else if (flush) begin
            stage_valid <= 1'b0;                // flush wins over a new accept
        end else if (ex_allowin) begin
            stage_valid <= id_to_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            inst <= id_to_ex_bus;
        end
    end

    // first resident cycle of each accepted instruction
    always_ff @(posedge clk) begin
        if (!resetn) begin
            alu_start <= 1'b0;
        end else begin
            alu_start <= load & ~flush;
        end
    end

    assign counter_half = inst.counter_low ? counter[31:0] : counter[63:32];
    assign result_sel   = inst.read_counter ? counter_half : alu_result;

    always_comb begin
        ex_to_id_bus.res_from_mem = inst.res_from_mem & stage_valid;
        ex_to_id_bus.rf_we        = inst.rf_we & stage_valid;
        ex_to_id_bus.rf_waddr     = inst.rf_waddr;
        ex_to_id_bus.result       = result_sel;
    end

    always_comb begin
        ex_to_mem_bus.pc           = inst.pc;
        ex_to_mem_bus.res_from_mem = inst.res_from_mem & stage_valid;
        ex_to_mem_bus.rf_we        = inst.rf_we & stage_valid;
        ex_to_mem_bus.rf_waddr     = inst.rf_waddr;
        ex_to_mem_bus.result       = result_sel;
        ex_to_mem_bus.addr_lo      = alu_result[1:0];  // byte offset of the access
        ex_to_mem_bus.size         = inst.size;
        ex_to_mem_bus.is_unsigned  = inst.is_unsigned;
        ex_to_mem_bus.excep_ale    = ale;
        ex_to_mem_bus.excep_en     = inst.excep_in | ale;
    end

endmodule

/* design/ex_lsu_req.sv */
module ex_lsu_req (
    input  logic                stage_valid,
    input  ex_pkg::ex_in_t      inst,
    input  logic [31:0]         addr,
    input  logic                older_excep,
    output logic                ale,
    output lsu_pkg::mem_req_t   data_sram_req
);

    logic       mem_op;     // load or store
    logic       misalign;
    logic [3:0] byte_we;
    logic [31:0] wdata;

    assign mem_op = inst.res_from_mem | inst.mem_we;

    always_comb begin
        case (inst.size)
            lsu_pkg::SIZE_BYTE: begin
                byte_we  = 4'b0001 << addr[1:0];
                wdata    = {4{inst.rkd[7:0]}};
                misalign = 1'b0;
            end
            lsu_pkg::SIZE_HALF: begin
                byte_we  = addr[1] ? 4'b1100 : 4'b0011;
                wdata    = {2{inst.rkd[15:0]}};
                misalign = addr[0];
            end
            default: begin
                byte_we  = 4'b1111;
                wdata    = inst.rkd;
                misalign = |addr[1:0];
            end
        endcase
    end

    // only memory instructions can fault on alignment
    assign ale = stage_valid & mem_op & misalign;

    always_comb begin
        data_sram_req.en    = stage_valid & mem_op & ~ale & ~inst.excep_in & ~older_excep;
        data_sram_req.we    = {4{data_sram_req.en & inst.mem_we}} & byte_we;
        data_sram_req.addr  = addr;
        data_sram_req.wdata = wdata;
    end

endmodule

/* design/ex_pkg.sv */
package ex_pkg;

    localparam int MUL_STEPS = 32;                 // shift-add iterations per multiply
    localparam int MUL_CNT_W = $clog2(MUL_STEPS);  // width of the remaining-steps counter
    localparam logic [MUL_CNT_W-1:0] MUL_LAST = MUL_CNT_W'(MUL_STEPS - 1);

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_NOR  = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11,
        ALU_MUL  = 4'd12
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        logic [31:0]    pc;
        alu_op_e        alu_op;
        logic [31:0]    src1;
        logic [31:0]    src2;
        logic [31:0]    rkd;          // store data
        logic           res_from_mem; // load
        logic           mem_we;       // store
        logic           rf_we;
        logic [4:0]     rf_waddr;
        lsu_pkg::size_e size;
        logic           is_unsigned;
        logic           read_counter; // rdcntv{l,h}.w
        logic           counter_low;
        logic           excep_in;     // merged causes from earlier stages
    } ex_in_t;

    // execute back to decode for bypass and load-use stalls
    typedef struct packed {
        logic        res_from_mem;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] result;
    } ex_fwd_t;

    // execute to memory
    typedef struct packed {
        logic [31:0]    pc;
        logic           res_from_mem;
        logic           rf_we;
        logic [4:0]     rf_waddr;
        logic [31:0]    result;
        logic [1:0]     addr_lo;      // for load data alignment
        lsu_pkg::size_e size;
        logic           is_unsigned;
        logic           excep_ale;
        logic           excep_en;
    } ex_out_t;

endpackage

/* design/ex_stage.sv */
module ex_stage (
    input  logic               clk,
    input  logic               resetn,
    input  logic               id_to_ex_valid,
    input  ex_pkg::ex_in_t     id_to_ex_bus,
    input  logic               mem_allowin,
    input  logic               older_excep,     // fault in mem or wb
    input  logic               flush,
    input  logic [63:0]        counter,
    output logic               ex_allowin,
    output ex_pkg::ex_fwd_t    ex_to_id_bus,
    output logic               ex_to_mem_valid,
    output ex_pkg::ex_out_t    ex_to_mem_bus,
    output lsu_pkg::mem_req_t  data_sram_req
);

    ex_pkg::ex_in_t inst;
    logic           stage_valid;
    logic           alu_start;
    logic [31:0]    alu_result;
    logic           alu_complete;
    logic           ale;

    ex_ctrl ctrl_i (
        .clk             (clk),
        .resetn          (resetn),
        .id_to_ex_valid  (id_to_ex_valid),
        .id_to_ex_bus    (id_to_ex_bus),
        .mem_allowin     (mem_allowin),
        .flush           (flush),
        .counter         (counter),
        .alu_result      (alu_result),
        .alu_complete    (alu_complete),
        .ale             (ale),
        .ex_allowin      (ex_allowin),
        .ex_to_mem_valid (ex_to_mem_valid),
        .inst            (inst),
        .stage_valid     (stage_valid),
        .alu_start       (alu_start),
        .ex_to_id_bus    (ex_to_id_bus),
        .ex_to_mem_bus   (ex_to_mem_bus)
    );

    ex_alu alu_i (
        .clk      (clk),
        .resetn   (resetn),
        .start    (alu_start),
        .alu_op   (inst.alu_op),
        .src1     (inst.src1),
        .src2     (inst.src2),
        .result   (alu_result),
        .complete (alu_complete)
    );

    ex_lsu_req lsu_req_i (
        .stage_valid   (stage_valid),
        .inst          (inst),
        .addr          (alu_result),    // effective address from the adder
        .older_excep   (older_excep),
        .ale           (ale),
        .data_sram_req (data_sram_req)
    );

endmodule

/* design/lsu_pkg.sv */
package lsu_pkg;

    // access width carried with loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    // request to the synchronous data sram
    typedef struct packed {
        logic        en;    // chip enable
        logic [3:0]  we;    // byte write enables
        logic [31:0] addr;  // byte address
        logic [31:0] wdata; // lane-replicated store data
    } mem_req_t;

endpackage

/* dv/ex_stage_chk.sv */
module ex_stage_chk (
    input  logic              clk,
    input  logic              resetn,
    input  logic              flush,
    input  logic              ex_to_mem_valid,
    input  logic              mem_allowin,
    input  ex_pkg::ex_in_t    inst,
    input  ex_pkg::ex_out_t   ex_to_mem_bus,
    input  lsu_pkg::mem_req_t data_sram_req
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;   // read by the testbench

    // a counter read follows the live counter, all else holds
    stall_hold: assert property (@(posedge clk) disable iff (!resetn)
        ex_to_mem_valid && !mem_allowin && !flush |=> ex_to_mem_valid
            && $stable({ex_to_mem_bus.pc, ex_to_mem_bus.rf_we, ex_to_mem_bus.rf_waddr,
                        ex_to_mem_bus.addr_lo, ex_to_mem_bus.size, ex_to_mem_bus.excep_en})
            && (inst.read_counter || $stable(ex_to_mem_bus.result)))
        else begin
            $error("execute bus changed while stalled by the memory stage");
            assert_fails++;
        end

    we_needs_en: assert property (@(posedge clk)
        (data_sram_req.we != 4'b0000) |-> data_sram_req.en)
        else begin
            $error("data sram byte write enables without chip enable");
            assert_fails++;
        end

    idle_after_reset: assert property (@(posedge clk)
        !resetn |=> !ex_to_mem_valid && !data_sram_req.en)
        else begin
            $error("stage not empty after a reset cycle");
            assert_fails++;
        end

endmodule

bind ex_stage ex_stage_chk chk_i (
    .clk             (clk),
    .resetn          (resetn),
    .flush           (flush),
    .ex_to_mem_valid (ex_to_mem_valid),
    .mem_allowin     (mem_allowin),
    .inst            (inst),
    .ex_to_mem_bus   (ex_to_mem_bus),
    .data_sram_req   (data_sram_req)
);

/* dv/ex_stage_tb.sv */
module ex_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INSTS      = 200;
    localparam int TIMEOUT_CYCLES = NUM_INSTS * 50 + NUM_INSTS;
    localparam int KIND_ALU       = 0;
    localparam int KIND_MEM       = 1;
    localparam int KIND_CNT       = 2;
    localparam int KIND_MIX       = 3;

    logic              clk;
    logic              resetn;
    logic              id_to_ex_valid;
    ex_pkg::ex_in_t    id_to_ex_bus;
    logic              mem_allowin;
    logic              older_excep;
    logic              flush;
    logic [63:0]       counter;
    logic              ex_allowin;
    ex_pkg::ex_fwd_t   ex_to_id_bus;
    logic              ex_to_mem_valid;
    ex_pkg::ex_out_t   ex_to_mem_bus;
    lsu_pkg::mem_req_t data_sram_req;

    logic [31:0]    lfsr;
    logic [31:0]    pc_next;
    ex_pkg::ex_in_t model_q[$];   // accepted and not yet departed
    logic           accepted;
    int             res_cycles;   // resident cycles of the head
    int             err_cnt;
    int             cycle_cnt;
    int             departed;
    int             dropped;      // removed by flush
    int             departed_total;

    ex_stage ex_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        counter <= counter + 64'd1;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        int          k;
        val = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] exp_alu(input ex_pkg::ex_in_t i);
        logic [31:0] a;
        logic [31:0] b;
        a = i.src1;
        b = i.src2;
        case (i.alu_op)
            ex_pkg::ALU_ADD:  return a + b;
            ex_pkg::ALU_SUB:  return a - b;
            ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ex_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ex_pkg::ALU_AND:  return a & b;
            ex_pkg::ALU_OR:   return a | b;
            ex_pkg::ALU_NOR:  return ~(a | b);
            ex_pkg::ALU_XOR:  return a ^ b;
            ex_pkg::ALU_SLL:  return a << b[4:0];
            ex_pkg::ALU_SRL:  return a >> b[4:0];
            ex_pkg::ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            ex_pkg::ALU_LUI:  return b;            // decode supplies the shifted immediate
            ex_pkg::ALU_MUL:  return a * b;        // low word only
            default:          return 32'd0;
        endcase
    endfunction

    function automatic logic exp_ale(input ex_pkg::ex_in_t i);
        logic [31:0] a;
        a = exp_alu(i);
        if (!(i.res_from_mem | i.mem_we)) begin
            return 1'b0;
        end
        if (i.size == lsu_pkg::SIZE_HALF) begin
            return a[0];
        end
        return (i.size == lsu_pkg::SIZE_WORD) && (a[1:0] != 2'b00);
    endfunction

    function automatic ex_pkg::ex_out_t exp_bus(input ex_pkg::ex_in_t i);
        ex_pkg::ex_out_t o;
        logic [31:0]     alu;
        alu            = exp_alu(i);
        o.pc           = i.pc;
        o.res_from_mem = i.res_from_mem;
        o.rf_we        = i.rf_we;
        o.rf_waddr     = i.rf_waddr;
        o.result       = !i.read_counter ? alu : (i.counter_low ? counter[31:0] : counter[63:32]);
        o.addr_lo      = alu[1:0];
        o.size         = i.size;
        o.is_unsigned  = i.is_unsigned;
        o.excep_ale    = exp_ale(i);
        o.excep_en     = i.excep_in | o.excep_ale;
        return o;
    endfunction

    function automatic lsu_pkg::mem_req_t exp_req(input ex_pkg::ex_in_t i);
        lsu_pkg::mem_req_t r;
        logic [3:0]        be;
        r.addr = exp_alu(i);
        case (i.size)
            lsu_pkg::SIZE_BYTE: begin
                be      = 4'b0001 << r.addr[1:0];
                r.wdata = {4{i.rkd[7:0]}};
            end
            lsu_pkg::SIZE_HALF: begin
                be      = r.addr[1] ? 4'b1100 : 4'b0011;
                r.wdata = {2{i.rkd[15:0]}};
            end
            default: begin
                be      = 4'b1111;
                r.wdata = i.rkd;
            end
        endcase
        r.en = (i.res_from_mem | i.mem_we) & ~exp_ale(i) & ~i.excep_in & ~older_excep;
        r.we = (r.en & i.mem_we) ? be : 4'b0000;
        return r;
    endfunction

    function automatic ex_pkg::ex_in_t gen_inst(input int kind, input int idx);
        ex_pkg::ex_in_t i;
        int             k;
        i          = '0;
        k          = (kind == KIND_MIX) ? int'(rand_bits(2)) % 3 : kind;
        i.pc       = pc_next;
        pc_next    = pc_next + 32'd4;
        i.rf_waddr = 5'(rand_bits(5));
        i.size     = lsu_pkg::SIZE_WORD;
        i.alu_op   = ex_pkg::ALU_ADD;
        i.src1     = rand_bits(32);
        i.src2     = rand_bits(32);
        if (k == KIND_ALU) begin
            i.alu_op = ex_pkg::alu_op_e'(rand_bits(4) % 13);
            i.rf_we  = 1'(rand_bits(1));
        end else if (k == KIND_MEM) begin
            i.src1         = i.src1 & 32'hffff_fffc;
            i.src2         = (rand_bits(10) << 2) | 32'(idx % 4);   // walks every offset
            i.size         = lsu_pkg::size_e'((idx / 4) % 3);
            i.mem_we       = 1'(rand_bits(1));
            i.res_from_mem = ~i.mem_we;
            i.rf_we        = i.res_from_mem;
            i.is_unsigned  = 1'(rand_bits(1));
            i.rkd          = rand_bits(32);
            i.excep_in     = (rand_bits(3) == 0);
        end else begin
            i.read_counter = 1'b1;
            i.counter_low  = 1'(rand_bits(1));
            i.rf_we        = 1'b1;
        end
        return i;
    endfunction

    function automatic int total_errors();
        return err_cnt + ex_stage_i.chk_i.assert_fails;
    endfunction

    task automatic check_val(input string name, input logic [95:0] got, input logic [95:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got %0h exp %0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_departure(input ex_pkg::ex_in_t cur);
        ex_pkg::ex_out_t   eb;
        lsu_pkg::mem_req_t er;
        eb = exp_bus(cur);
        er = exp_req(cur);
        check_val("ex_to_mem_bus.pc", ex_to_mem_bus.pc, eb.pc);
        check_val("ex_to_mem_bus.result", ex_to_mem_bus.result, eb.result);
        check_val("ex_to_mem_bus.excep_ale", ex_to_mem_bus.excep_ale, eb.excep_ale);
        check_val("ex_to_mem_bus.excep_en", ex_to_mem_bus.excep_en, eb.excep_en);
        check_val("ex_to_mem_bus", ex_to_mem_bus, eb);
        check_val("data_sram_req.en", data_sram_req.en, er.en);
        check_val("data_sram_req.we", data_sram_req.we, er.we);
        check_val("data_sram_req.addr", data_sram_req.addr, er.addr);
        check_val("data_sram_req.wdata", data_sram_req.wdata, er.wdata);
    endtask

    // called mid cycle, decides what the coming edge does
    task automatic sample_cycle();
        ex_pkg::ex_in_t  cur;
        ex_pkg::ex_out_t eb;
        logic            resident;
        logic            ready;
        resident = (model_q.size() != 0);
        ready    = 1'b0;
        cur      = '0;
        if (resident) begin
            cur = model_q[0];
            res_cycles++;
            ready = (cur.alu_op != ex_pkg::ALU_MUL) || (res_cycles > ex_pkg::MUL_STEPS);
        end
        check_val("ex_to_mem_valid", ex_to_mem_valid, resident & ready);
        check_val("ex_allowin", ex_allowin, !resident || (ready && mem_allowin));
        check_val("ex_to_id_bus.rf_we", ex_to_id_bus.rf_we, resident & cur.rf_we);
        check_val("ex_to_id_bus.res_from_mem", ex_to_id_bus.res_from_mem,
                  resident & cur.res_from_mem);
        if (!resident) begin
            check_val("data_sram_req.en", data_sram_req.en, 1'b0);
            check_val("data_sram_req.we", data_sram_req.we, 4'h0);
        end else begin
            check_val("ex_to_id_bus.rf_waddr", ex_to_id_bus.rf_waddr, cur.rf_waddr);
        end
        if (resident && ready) begin
            eb = exp_bus(cur);
            check_val("ex_to_id_bus.result", ex_to_id_bus.result, eb.result);
        end
        if (ex_to_mem_valid && mem_allowin) begin
            assert (resident) else begin
                $display("a departure appeared while the stage should be empty");
                err_cnt++;
            end
            if (resident) begin
                check_departure(cur);
                void'(model_q.pop_front());
                departed++;
            end
        end
        accepted = id_to_ex_valid && ex_allowin;
        if (flush) begin
            dropped += model_q.size() + (accepted ? 1 : 0);
            model_q.delete();
        end else if (accepted) begin
            model_q.push_back(id_to_ex_bus);
            res_cycles = 0;
        end
    endtask

    task automatic run_test(input string name, input int kind, input int n);
        int   issued;
        int   err_start;
        logic presenting;
        issued     = 0;
        departed   = 0;
        dropped    = 0;
        presenting = 1'b0;
        err_start  = total_errors();
        while (issued < n || presenting || model_q.size() != 0) begin
            @(negedge clk);
            sample_cycle();
            @(posedge clk);
            mem_allowin <= (rand_bits(2) != 0);
            older_excep <= (kind == KIND_MEM) && (rand_bits(3) == 0);
            flush       <= (kind == KIND_MIX) && (rand_bits(5) == 0);
            if (accepted || !presenting) begin
                presenting = (issued < n) && (rand_bits(2) != 0);
                if (presenting) begin
                    id_to_ex_bus <= gen_inst(kind, issued);
                    issued++;
                end
                id_to_ex_valid <= presenting;
            end
        end
        assert (departed + dropped == n) else begin
            $display("test %s lost or duplicated instructions", name);
            err_cnt++;
        end
        departed_total += departed;
        $display("test %s: %0d issued, %0d departed, %0d flushed, %0d errors",
                 name, n, departed, dropped, total_errors() - err_start);
    endtask

    initial begin
        lfsr           = 32'hbc574125;
        pc_next        = 32'h1c00_0000;
        counter        = 64'h0000_0001_ffff_ff00;   // low word wraps early in the run
        err_cnt        = 0;
        cycle_cnt      = 0;
        departed_total = 0;
        res_cycles     = 0;
        accepted       = 1'b0;
        resetn         = 1'b0;
        id_to_ex_valid = 1'b0;
        id_to_ex_bus   = '0;
        mem_allowin    = 1'b0;
        older_excep    = 1'b0;
        flush          = 1'b0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        run_test("alu_ops", KIND_ALU, 60);
        run_test("mem_access", KIND_MEM, 60);
        run_test("counter_read", KIND_CNT, 30);
        run_test("mixed_flush", KIND_MIX, 50);
        $display("4 tests, %0d departures, %0d errors", departed_total, total_errors());
        if (total_errors() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
